//--- line_pkg.sv
`default_nettype none

package line_pkg;

  // one screen coordinate, x or y
  localparam int coord_w = 10;

  // pixel word, rgb in the low 24 bits
  localparam int color_w = 32;

  // frame select field inside the memory address
  localparam int frame_sel_w = 6;

  // memory side of the fifos
  localparam int af_addr_w = 31;
  localparam int wdf_data_w = 4 * color_w;
  localparam int wdf_mask_w = wdf_data_w / 8;

  // packed host point, x on top
  localparam int point_w = 2 * coord_w;

  // stepper fsm
  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_run
  } stepper_state_t;

  // writer fsm, one beat per state
  typedef enum logic [1:0] {
    wr_idle,
    wr_beat1,
    wr_beat2
  } writer_state_t;

endpackage

`default_nettype wire

//--- line_regs.sv
`default_nettype none

module line_regs (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [line_pkg::color_w-1:0]    color,
  input  wire logic [line_pkg::point_w-1:0]    point,
  input  wire logic                            color_valid,
  input  wire logic                            point0_valid,
  input  wire logic                            point1_valid,
  input  wire logic [31:0]                     frame_base,
  input  wire logic                            trigger,
  input  wire logic                            line_done,
  output logic                                 ready,
  output logic                                 start,
  output logic [line_pkg::coord_w-1:0]         x0,
  output logic [line_pkg::coord_w-1:0]         y0,
  output logic [line_pkg::coord_w-1:0]         x1,
  output logic [line_pkg::coord_w-1:0]         y1,
  output logic [line_pkg::color_w-1:0]         pix_color,
  output logic [line_pkg::frame_sel_w-1:0]     frame_sel
);

  logic busy;
  logic accept;

  // host writes only count while no line is in flight
  assign accept = trigger && !busy;
  assign ready = !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (line_done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy) begin
      if (color_valid) begin
        pix_color <= color;
      end
      if (point0_valid) begin
        x0 <= point[line_pkg::point_w-1:line_pkg::coord_w];
        y0 <= point[line_pkg::coord_w-1:0];
      end
      if (point1_valid) begin
        x1 <= point[line_pkg::point_w-1:line_pkg::coord_w];
        y1 <= point[line_pkg::coord_w-1:0];
      end
      // frame base has no strobe, sampled with the trigger
      if (trigger) begin
        frame_sel <= {3'b000, frame_base[24:22]};
      end
    end
  end

  // the writer only finishes a line that was started
  a_done_busy: assert property (@(posedge clk) disable iff (rst)
    line_done |-> busy);

endmodule

`default_nettype wire

//--- line_stepper.sv
`default_nettype none

module line_stepper (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        start,
  input  wire logic [line_pkg::coord_w-1:0] x0,
  input  wire logic [line_pkg::coord_w-1:0] y0,
  input  wire logic [line_pkg::coord_w-1:0] x1,
  input  wire logic [line_pkg::coord_w-1:0] y1,
  input  wire logic                        pixel_take,
  output logic                             pixel_valid,
  output logic [line_pkg::coord_w-1:0]     pixel_x,
  output logic [line_pkg::coord_w-1:0]     pixel_y,
  output logic                             last_pixel
);

  line_pkg::stepper_state_t state;

  // setup values, combinational from the held endpoints
  logic [line_pkg::coord_w-1:0] adx;
  logic [line_pkg::coord_w-1:0] ady;
  logic                         steep_c;
  logic [line_pkg::coord_w-1:0] ma0;
  logic [line_pkg::coord_w-1:0] mb0;
  logic [line_pkg::coord_w-1:0] ma1;
  logic [line_pkg::coord_w-1:0] mb1;
  logic [line_pkg::coord_w-1:0] sa;
  logic [line_pkg::coord_w-1:0] sb;
  logic [line_pkg::coord_w-1:0] ea;
  logic [line_pkg::coord_w-1:0] eb;
  logic [line_pkg::coord_w-1:0] dx_c;

  // run registers, a is the major axis
  logic                           steep;
  logic [line_pkg::coord_w-1:0]   a_cur;
  logic [line_pkg::coord_w-1:0]   b_cur;
  logic [line_pkg::coord_w-1:0]   a_end;
  logic [line_pkg::coord_w-1:0]   dx;
  logic [line_pkg::coord_w-1:0]   dy;
  logic                           b_up;
  logic signed [line_pkg::coord_w+1:0] err;
  logic signed [line_pkg::coord_w+1:0] err_sub;

  function automatic logic [line_pkg::coord_w-1:0] abs_diff(
    input logic [line_pkg::coord_w-1:0] a,
    input logic [line_pkg::coord_w-1:0] b
  );
    return (a > b) ? a - b : b - a;
  endfunction

  always_comb begin
    adx = abs_diff(x0, x1);
    ady = abs_diff(y0, y1);
    steep_c = ady > adx;
    ma0 = steep_c ? y0 : x0;
    mb0 = steep_c ? x0 : y0;
    ma1 = steep_c ? y1 : x1;
    mb1 = steep_c ? x1 : y1;
    // walk from the lower major coordinate
    if (ma0 > ma1) begin
      sa = ma1;
      sb = mb1;
      ea = ma0;
      eb = mb0;
    end else begin
      sa = ma0;
      sb = mb0;
      ea = ma1;
      eb = mb1;
    end
    dx_c = ea - sa;
  end

  assign err_sub = err - signed'({2'b00, dy});

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= line_pkg::st_idle;
    end else begin
      case (state)
        line_pkg::st_idle: begin
          if (start) begin
            state <= line_pkg::st_setup;
          end
        end
        line_pkg::st_setup: begin
          state <= line_pkg::st_run;
        end
        line_pkg::st_run: begin
          if (pixel_take && last_pixel) begin
            state <= line_pkg::st_idle;
          end
        end
        default: begin
          state <= line_pkg::st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == line_pkg::st_setup) begin
      steep <= steep_c;
      a_cur <= sa;
      b_cur <= sb;
      a_end <= ea;
      dx    <= dx_c;
      dy    <= abs_diff(sb, eb);
      b_up  <= eb > sb;
      err   <= signed'({3'b000, dx_c[line_pkg::coord_w-1:1]});
    end else if (state == line_pkg::st_run && pixel_take && !last_pixel) begin
      a_cur <= a_cur + 1'b1;
      if (err_sub < 0) begin
        b_cur <= b_up ? b_cur + 1'b1 : b_cur - 1'b1;
        err   <= err_sub + signed'({2'b00, dx});
      end else begin
        err <= err_sub;
      end
    end
  end

  assign pixel_valid = (state == line_pkg::st_run);
  assign last_pixel  = pixel_valid && (a_cur == a_end);
  // undo the steep swap
  assign pixel_x = steep ? b_cur : a_cur;
  assign pixel_y = steep ? a_cur : b_cur;

  a_take_valid: assert property (@(posedge clk) disable iff (rst)
    pixel_take |-> pixel_valid);

  // a new line only starts once the previous one is out
  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> state == line_pkg::st_idle);

endmodule

`default_nettype wire

//--- line_writer.sv
`default_nettype none

module line_writer (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             pixel_valid,
  input  wire logic [line_pkg::coord_w-1:0]     pixel_x,
  input  wire logic [line_pkg::coord_w-1:0]     pixel_y,
  input  wire logic                             last_pixel,
  input  wire logic [line_pkg::color_w-1:0]     pix_color,
  input  wire logic [line_pkg::frame_sel_w-1:0] frame_sel,
  input  wire logic                             af_full,
  input  wire logic                             wdf_full,
  output logic                                  pixel_take,
  output logic                                  line_done,
  output logic [line_pkg::af_addr_w-1:0]        af_addr_din,
  output logic                                  af_wr_en,
  output logic [line_pkg::wdf_data_w-1:0]       wdf_din,
  output logic [line_pkg::wdf_mask_w-1:0]       wdf_mask_din,
  output logic                                  wdf_wr_en
);

  line_pkg::writer_state_t state;

  logic       can_write;
  logic       beat1_fire;
  logic       beat2_fire;
  logic       word_hit;
  logic [1:0] word_sel;

  // both fifos must have room, the command and beat 1 go together
  assign can_write = !af_full && !wdf_full;

  // wr_idle also issues beat 1, so the first pixel costs no extra cycle
  assign beat1_fire = (state != line_pkg::wr_beat2) && pixel_valid && can_write;
  assign beat2_fire = (state == line_pkg::wr_beat2) && can_write;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= line_pkg::wr_idle;
    end else begin
      case (state)
        line_pkg::wr_idle,
        line_pkg::wr_beat1: begin
          if (beat1_fire) begin
            state <= line_pkg::wr_beat2;
          end
        end
        line_pkg::wr_beat2: begin
          if (beat2_fire) begin
            state <= last_pixel ? line_pkg::wr_idle : line_pkg::wr_beat1;
          end
        end
        default: begin
          state <= line_pkg::wr_idle;
        end
      endcase
    end
  end

  assign af_wr_en   = beat1_fire;
  assign wdf_wr_en  = beat1_fire || beat2_fire;
  assign pixel_take = beat2_fire;
  assign line_done  = beat2_fire && last_pixel;

  // eight words per burst, x[9:3] picks the burst
  assign af_addr_din = {6'b000000, frame_sel, pixel_y, pixel_x[9:3], 2'b00};
  assign wdf_din = {4{pix_color}};

  // words 0..3 of a burst sit in beat 1, high word first
  assign word_sel = ~pixel_x[1:0];
  assign word_hit = (beat1_fire && !pixel_x[2]) || (beat2_fire && pixel_x[2]);

  always_comb begin
    wdf_mask_din = '1;
    if (word_hit) begin
      wdf_mask_din[word_sel*4 +: 4] = 4'h0;
    end
  end

  // beat 2 goes out for the same pixel as its command
  a_pixel_held: assert property (@(posedge clk) disable iff (rst)
    state == line_pkg::wr_beat2 |-> $stable(pixel_x) && $stable(pixel_y));

  // stepper must have the next pixel ready right after a take
  a_next_pixel: assert property (@(posedge clk) disable iff (rst)
    state == line_pkg::wr_beat1 |-> pixel_valid);

endmodule

`default_nettype wire

//--- line_engine_top.sv
`default_nettype none

module line_engine_top (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [line_pkg::color_w-1:0]  color,
  input  wire logic [line_pkg::point_w-1:0]  point,
  input  wire logic                          color_valid,
  input  wire logic                          point0_valid,
  input  wire logic                          point1_valid,
  input  wire logic [31:0]                   frame_base,
  input  wire logic                          trigger,
  input  wire logic                          af_full,
  input  wire logic                          wdf_full,
  output logic                               ready,
  output logic [line_pkg::af_addr_w-1:0]     af_addr_din,
  output logic                               af_wr_en,
  output logic [line_pkg::wdf_data_w-1:0]    wdf_din,
  output logic [line_pkg::wdf_mask_w-1:0]    wdf_mask_din,
  output logic                               wdf_wr_en
);

  logic                             start;
  logic [line_pkg::coord_w-1:0]     x0;
  logic [line_pkg::coord_w-1:0]     y0;
  logic [line_pkg::coord_w-1:0]     x1;
  logic [line_pkg::coord_w-1:0]     y1;
  logic [line_pkg::color_w-1:0]     pix_color;
  logic [line_pkg::frame_sel_w-1:0] frame_sel;
  logic                             pixel_valid;
  logic [line_pkg::coord_w-1:0]     pixel_x;
  logic [line_pkg::coord_w-1:0]     pixel_y;
  logic                             last_pixel;
  logic                             pixel_take;
  logic                             line_done;

  line_regs i_regs (
    .clk          (clk),
    .rst          (rst),
    .color        (color),
    .point        (point),
    .color_valid  (color_valid),
    .point0_valid (point0_valid),
    .point1_valid (point1_valid),
    .frame_base   (frame_base),
    .trigger      (trigger),
    .line_done    (line_done),
    .ready        (ready),
    .start        (start),
    .x0           (x0),
    .y0           (y0),
    .x1           (x1),
    .y1           (y1),
    .pix_color    (pix_color),
    .frame_sel    (frame_sel)
  );

  line_stepper i_stepper (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .x0          (x0),
    .y0          (y0),
    .x1          (x1),
    .y1          (y1),
    .pixel_take  (pixel_take),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .last_pixel  (last_pixel)
  );

  line_writer i_writer (
    .clk          (clk),
    .rst          (rst),
    .pixel_valid  (pixel_valid),
    .pixel_x      (pixel_x),
    .pixel_y      (pixel_y),
    .last_pixel   (last_pixel),
    .pix_color    (pix_color),
    .frame_sel    (frame_sel),
    .af_full      (af_full),
    .wdf_full     (wdf_full),
    .pixel_take   (pixel_take),
    .line_done    (line_done),
    .af_addr_din  (af_addr_din),
    .af_wr_en     (af_wr_en),
    .wdf_din      (wdf_din),
    .wdf_mask_din (wdf_mask_din),
    .wdf_wr_en    (wdf_wr_en)
  );

endmodule

`default_nettype wire

//--- tb_line_engine.sv
`default_nettype none

module tb_line_engine;
  timeunit 1ns;
  timeprecision 1ps;

  logic         clk;
  logic         rst;
  logic [31:0]  color;
  logic [19:0]  point;
  logic         color_valid;
  logic         point0_valid;
  logic         point1_valid;
  logic [31:0]  frame_base;
  logic         trigger;
  logic         af_full = 1'b0;
  logic         wdf_full = 1'b0;
  logic         ready;
  logic [30:0]  af_addr_din;
  logic         af_wr_en;
  logic [127:0] wdf_din;
  logic [15:0]  wdf_mask_din;
  logic         wdf_wr_en;

  // captured writes, one entry per pixel
  logic [30:0]  got_addr[$];
  logic [15:0]  got_mask1[$];
  logic [15:0]  got_mask2[$];
  logic [127:0] got_data1[$];
  logic [127:0] got_data2[$];
  logic [30:0]  exp_addr[$];
  logic [15:0]  exp_mask1[$];
  logic [15:0]  exp_mask2[$];
  logic [127:0] exp_data[$];
  int           beat_count = 0;
  int           full_cycles = 0;
  bit           beat2_pending = 1'b0;
  bit           random_full = 1'b0;
  integer       seed = 32'hbc12;
  int           base_idx;
  int           base_beats;
  int           base_full;

  line_engine_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .color        (color),
    .point        (point),
    .color_valid  (color_valid),
    .point0_valid (point0_valid),
    .point1_valid (point1_valid),
    .frame_base   (frame_base),
    .trigger      (trigger),
    .af_full      (af_full),
    .wdf_full     (wdf_full),
    .ready        (ready),
    .af_addr_din  (af_addr_din),
    .af_wr_en     (af_wr_en),
    .wdf_din      (wdf_din),
    .wdf_mask_din (wdf_mask_din),
    .wdf_wr_en    (wdf_wr_en)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("** Error: %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // fifo full flags, random only during the back-pressure test
  always @(negedge clk) begin
    if (random_full) begin
      af_full  = ($random(seed) & 3) == 0;
      wdf_full = ($random(seed) & 3) == 0;
    end else begin
      af_full  = 1'b0;
      wdf_full = 1'b0;
    end
  end

  // fifo sink, pairs each command with its two data beats
  always @(posedge clk) begin
    if (!rst) begin
      if (af_full || wdf_full) begin
        full_cycles++;
      end
      if (af_wr_en && af_full) begin
        stop_on_error("address FIFO was written while it was full");
      end
      if (wdf_wr_en && wdf_full) begin
        stop_on_error("write data FIFO was written while it was full");
      end
      if (af_wr_en && !wdf_wr_en) begin
        stop_on_error("command was written without a data beat");
      end
      if (wdf_wr_en) begin
        beat_count++;
      end
      if (af_wr_en) begin
        if (beat2_pending) begin
          stop_on_error("new command arrived before beat 2 of the previous pixel");
        end
        got_addr.push_back(af_addr_din);
        got_mask1.push_back(wdf_mask_din);
        got_data1.push_back(wdf_din);
        beat2_pending = 1'b1;
      end else if (wdf_wr_en) begin
        if (!beat2_pending) begin
          stop_on_error("data beat arrived without a command");
        end
        got_mask2.push_back(wdf_mask_din);
        got_data2.push_back(wdf_din);
        beat2_pending = 1'b0;
      end
    end
  end

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  task automatic swap_int(inout int a, inout int b);
    int t;
    t = a;
    a = b;
    b = t;
  endtask

  task automatic add_expected(input int px, input int py, input logic [31:0] col,
                              input logic [31:0] fb);
    logic [9:0]  xs;
    logic [9:0]  ys;
    logic [15:0] m1;
    logic [15:0] m2;
    int          p;
    xs = px[9:0];
    ys = py[9:0];
    p = int'(xs[2:0]);
    m1 = 16'hffff;
    m2 = 16'hffff;
    // word 3 sits at mask bits 15:12, active low
    if (p < 4) begin
      m1[4*(3-p) +: 4] = 4'h0;
    end else begin
      m2[4*(7-p) +: 4] = 4'h0;
    end
    exp_addr.push_back({6'b000000, 3'b000, fb[24:22], ys, xs[9:3], 2'b00});
    exp_mask1.push_back(m1);
    exp_mask2.push_back(m2);
    exp_data.push_back({4{col}});
  endtask

  // reference rasterizer, ascending major coordinate
  task automatic build_expected(input int x0, input int y0, input int x1, input int y1,
                                input logic [31:0] col, input logic [31:0] fb);
    int  ax0;
    int  ay0;
    int  ax1;
    int  ay1;
    int  dx;
    int  dy;
    int  err;
    int  ystep;
    int  y;
    bit  steep;
    exp_addr.delete();
    exp_mask1.delete();
    exp_mask2.delete();
    exp_data.delete();
    ax0 = x0;
    ay0 = y0;
    ax1 = x1;
    ay1 = y1;
    steep = abs_int(ay1 - ay0) > abs_int(ax1 - ax0);
    if (steep) begin
      swap_int(ax0, ay0);
      swap_int(ax1, ay1);
    end
    if (ax0 > ax1) begin
      swap_int(ax0, ax1);
      swap_int(ay0, ay1);
    end
    dx = ax1 - ax0;
    dy = abs_int(ay1 - ay0);
    err = dx / 2;
    ystep = (ay0 < ay1) ? 1 : -1;
    y = ay0;
    for (int x = ax0; x <= ax1; x++) begin
      if (steep) begin
        add_expected(y, x, col, fb);
      end else begin
        add_expected(x, y, col, fb);
      end
      err = err - dy;
      if (err < 0) begin
        y = y + ystep;
        err = err + dx;
      end
    end
  endtask

  task automatic mark_capture();
    base_idx = got_addr.size();
    base_beats = beat_count;
    base_full = full_cycles;
  endtask

  task automatic wait_ready(input string name, input int limit);
    int n;
    n = 0;
    while (!ready && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!ready) begin
      stop_on_error($sformatf("%s: ready did not return, stepper state %0d", name,
                              i_dut.i_stepper.state));
    end
  endtask

  task automatic wait_first_command(input string name, input int limit);
    int n;
    n = 0;
    while (got_addr.size() == base_idx && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (got_addr.size() == base_idx) begin
      stop_on_error($sformatf("%s: no command was written", name));
    end
  endtask

  task automatic start_line(input logic [31:0] col, input int x0, input int y0,
                            input int x1, input int y1, input logic [31:0] fb);
    @(negedge clk);
    color = col;
    color_valid = 1'b1;
    point = {x0[9:0], y0[9:0]};
    point0_valid = 1'b1;
    @(negedge clk);
    color_valid = 1'b0;
    point0_valid = 1'b0;
    point = {x1[9:0], y1[9:0]};
    point1_valid = 1'b1;
    @(negedge clk);
    point1_valid = 1'b0;
    frame_base = fb;
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    check_value("ready low after trigger", 0, ready);
  endtask

  task automatic compare_writes(input string name);
    int n;
    n = got_addr.size() - base_idx;
    check_value({name, " pixel count"}, exp_addr.size(), n);
    check_value({name, " beat count"}, 2 * n, beat_count - base_beats);
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("%s pixel %0d address", name, i), exp_addr[i],
                  got_addr[base_idx+i]);
      check_value($sformatf("%s pixel %0d mask 1", name, i), exp_mask1[i],
                  got_mask1[base_idx+i]);
      check_value($sformatf("%s pixel %0d mask 2", name, i), exp_mask2[i],
                  got_mask2[base_idx+i]);
      check_value($sformatf("%s pixel %0d data 1", name, i), exp_data[i],
                  got_data1[base_idx+i]);
      check_value($sformatf("%s pixel %0d data 2", name, i), exp_data[i],
                  got_data2[base_idx+i]);
    end
  endtask

  task automatic draw_line(input string name, input logic [31:0] col, input int x0,
                           input int y0, input int x1, input int y1,
                           input logic [31:0] fb);
    mark_capture();
    build_expected(x0, y0, x1, y1, col, fb);
    start_line(col, x0, y0, x1, y1, fb);
    wait_ready(name, 4000);
    compare_writes(name);
  endtask

  task automatic verify_reset_outputs();
    check_value("reset ready", 1, ready);
    check_value("reset af_wr_en", 0, af_wr_en);
    check_value("reset wdf_wr_en", 0, wdf_wr_en);
    check_value("reset mask", 16'hffff, wdf_mask_din);
    check_value("reset start", 0, i_dut.i_regs.start);
    check_value("reset pixel_valid", 0, i_dut.i_stepper.pixel_valid);
    check_value("reset pixel_take", 0, i_dut.i_writer.pixel_take);
  endtask

  task automatic shallow_line();
    draw_line("shallow", 32'h00a1b2c3, 10, 5, 30, 12, 32'h01c0_0000);
    check_value("shallow command count", 21, got_addr.size() - base_idx);
  endtask

  task automatic steep_lines();
    draw_line("steep", 32'h00ff0000, 100, 50, 93, 80, 32'h0040_0000);
    draw_line("steep swapped", 32'h00ff0000, 93, 80, 100, 50, 32'h0040_0000);
  endtask

  task automatic fifo_back_pressure();
    random_full = 1'b1;
    draw_line("back-pressure", 32'h00a1b2c3, 10, 5, 30, 12, 32'h01c0_0000);
    random_full = 1'b0;
    check_value("back-pressure cycles seen", 1, full_cycles > base_full);
  endtask

  // loads during a line must not reach the line in flight
  task automatic config_hold();
    mark_capture();
    build_expected(0, 0, 60, 25, 32'h0000ff00, 32'h0140_0000);
    start_line(32'h0000ff00, 0, 0, 60, 25, 32'h0140_0000);
    wait_first_command("config hold", 100);
    color = 32'h00123456;
    color_valid = 1'b1;
    point = {10'd500, 10'd400};
    point0_valid = 1'b1;
    frame_base = 32'hfe40_0000;
    trigger = 1'b1;
    @(negedge clk);
    color_valid = 1'b0;
    point0_valid = 1'b0;
    trigger = 1'b0;
    point = {10'd470, 10'd450};
    point1_valid = 1'b1;
    @(negedge clk);
    point1_valid = 1'b0;
    check_value("config hold still drawing", 0, ready);
    wait_ready("config hold old line", 4000);
    compare_writes("config hold old line");
    // held endpoints and color still those of the old line
    check_value("config hold x0", 0, i_dut.i_regs.x0);
    check_value("config hold y0", 0, i_dut.i_regs.y0);
    check_value("config hold x1", 60, i_dut.i_regs.x1);
    check_value("config hold y1", 25, i_dut.i_regs.y1);
    check_value("config hold color", 32'h0000ff00, i_dut.i_regs.pix_color);
    draw_line("config hold new line", 32'h00123456, 500, 400, 470, 450, 32'hfe40_0000);
    check_value("config hold frame_sel", 6'd1, i_dut.i_regs.frame_sel);
  endtask

  task automatic single_point();
    draw_line("single point", 32'h00c0ffee, 200, 300, 200, 300, 32'h0080_0000);
    check_value("single point commands", 1, got_addr.size() - base_idx);
    check_value("single point beats", 2, beat_count - base_beats);
  endtask

  initial begin
    rst = 1'b1;
    color = '0;
    point = '0;
    color_valid = 1'b0;
    point0_valid = 1'b0;
    point1_valid = 1'b0;
    frame_base = '0;
    trigger = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    verify_reset_outputs();
    shallow_line();
    steep_lines();
    fifo_back_pressure();
    config_hold();
    single_point();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
line_pkg.sv
line_regs.sv
line_stepper.sv
line_writer.sv
line_engine_top.sv
tb_line_engine.sv

//--- Makefile
TOP := tb_line_engine
RTL := line_pkg.sv line_regs.sv line_stepper.sv line_writer.sv line_engine_top.sv

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f $(RTL) tb_line_engine.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --assert --top-module line_engine_top $(RTL)

clean:
	rm -rf obj_dir
